/* Makefile */
# Verilator build and run of the assignment engine testbench

VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_STR  ?= TESTBENCH PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
src/jam_pkg.sv
src/cost_loader.sv
src/cost_matrix.sv
src/col_reducer.sv
src/line_cover.sv
src/result_streamer.sv
src/jam_top.sv
verification/tb_clk_gen.sv
verification/jam_checker.sv
verification/tb_top.sv

/* src/col_reducer.sv */
`default_nettype none

module col_reducer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  jam_pkg::matrix_t  matrix,
	output logic              col_we,
	output jam_pkg::col_wr_t  col_wr,
	output logic              done
);
	import jam_pkg::*;

	logic  active;
	idx_t  col;      // column being reduced
	cost_t col_min;

	// ----------------------------------------
	// column minimum, compare chain down the rows
	// ----------------------------------------
	always_comb begin
		col_min = matrix[0][col];
		for (int r = 1; r < DIM; r++) begin
			if (matrix[r][col] < col_min)
				col_min = matrix[r][col];
		end
	end

	always_comb begin
		col_wr.idx = col;
		for (int r = 0; r < DIM; r++)
			col_wr.data[r] = matrix[r][col] - col_min;  // never negative
	end

	assign col_we = active;

	// one column per cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			col    <= '0;
			done   <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				active <= 1'b1;
				col    <= '0;
			end else if (active) begin
				col <= col + 1'b1;
				if (col == idx_t'(DIM-1)) begin
					active <= 1'b0;
					done   <= 1'b1;  // cycle after the last write
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/cost_loader.sv */
`default_nettype none

module cost_loader (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  jam_pkg::cost_t    in_cost,
	input  logic              out_done,
	output logic              row_we,
	output jam_pkg::row_wr_t  row_wr,
	output logic              load_done
);
	import jam_pkg::*;

	localparam int CNT_W = $clog2(DIM*DIM);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOAD,
		S_WAIT
	} state_t;

	state_t             state;
	logic [CNT_W-1:0]   in_cnt;   // accepted costs of this matrix
	logic               take;
	cost_t              cost_q;
	logic               cost_v;
	row_t               row_buf;  // shifts right, newest on top
	cost_t              run_min;
	idx_t               col_cnt;
	idx_t               row_cnt;
	row_t               row_full;
	cost_t              row_min;

	assign take = in_valid && (state != S_WAIT);  // busy until results are out

	// ----------------------------------------
	// input side
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= S_IDLE;
			in_cnt <= '0;
			cost_v <= 1'b0;
		end else begin
			cost_v <= take;
			if (take)
				in_cnt <= in_cnt + 1'b1;  // wraps to 0 after the 64th
			case (state)
				S_IDLE: if (in_valid) state <= S_LOAD;
				S_LOAD: if (take && in_cnt == CNT_W'(DIM*DIM-1)) state <= S_WAIT;
				S_WAIT: if (out_done) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			cost_q <= in_cost;
	end

	// ----------------------------------------
	// row assembly and row minimum
	// ----------------------------------------
	always_comb begin
		row_full = {cost_q, row_buf[DIM-1:1]};  // e0 lands at [0] on the 8th shift
		row_min  = (col_cnt == '0 || cost_q < run_min) ? cost_q : run_min;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_cnt   <= '0;
			row_cnt   <= '0;
			row_we    <= 1'b0;
			load_done <= 1'b0;
		end else begin
			row_we    <= cost_v && (col_cnt == idx_t'(DIM-1));
			load_done <= row_we && (row_wr.idx == idx_t'(DIM-1));
			if (cost_v) begin
				col_cnt <= col_cnt + 1'b1;
				if (col_cnt == idx_t'(DIM-1))
					row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cost_v) begin
			row_buf <= row_full;
			run_min <= row_min;
		end
		if (cost_v && col_cnt == idx_t'(DIM-1)) begin
			row_wr.idx <= row_cnt;
			for (int c = 0; c < DIM; c++)
				row_wr.data[c] <= row_full[c] - row_min;
		end
	end

	// a matrix arrives as one unbroken burst
	a_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
		(state == S_IDLE && in_valid) |=> in_valid [* DIM*DIM-1]);

endmodule

`default_nettype wire

/* src/cost_matrix.sv */
`default_nettype none

module cost_matrix #(
	parameter type elem_t = jam_pkg::cost_t
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              row_we,
	input  jam_pkg::row_wr_t  row_wr,
	input  logic              col_we,
	input  jam_pkg::col_wr_t  col_wr,
	output jam_pkg::matrix_t  matrix
);
	import jam_pkg::*;

	elem_t [DIM-1:0][DIM-1:0] store;  // [r][c]

	// ----------------------------------------
	// write ports
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			store <= '0;
		end else if (row_we) begin
			for (int c = 0; c < DIM; c++)
				store[row_wr.idx][c] <= elem_t'(row_wr.data[c]);
		end else if (col_we) begin
			// one column, every row
			for (int r = 0; r < DIM; r++)
				store[r][col_wr.idx] <= elem_t'(col_wr.data[r]);
		end
	end

	// whole contents out to the consumers
	always_comb begin
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++)
				matrix[r][c] = cost_t'(store[r][c]);
		end
	end

	// loader and column reducer own the store in turn
	a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
		!(row_we && col_we));

endmodule

`default_nettype wire

/* src/jam_pkg.sv */
`default_nettype none

package jam_pkg;

	// ----------------------------------------
	// sizes
	// ----------------------------------------
	localparam int DIM    = 8;  // matrix is DIM x DIM
	localparam int COST_W = 7;

	typedef logic [COST_W-1:0]        cost_t;
	typedef logic [$clog2(DIM)-1:0]   idx_t;       // row or column number
	typedef logic [$clog2(DIM):0]     cnt_t;       // zeros in one line, 0..8
	typedef logic [$clog2(DIM):0]     line_cnt_t;  // lines drawn, 0..8

	// ----------------------------------------
	// matrix views
	// ----------------------------------------
	typedef cost_t [DIM-1:0] row_t;     // [c] is column c
	typedef row_t  [DIM-1:0] matrix_t;  // [r][c]

	// one full row into the store
	typedef struct packed {
		idx_t idx;
		row_t data;
	} row_wr_t;

	// one full column into the store, data[r] goes to row r
	typedef struct packed {
		idx_t            idx;
		cost_t [DIM-1:0] data;
	} col_wr_t;

	// output beat
	typedef struct packed {
		row_t      row;
		line_cnt_t lines;
	} result_t;

endpackage

`default_nettype wire

/* src/jam_top.sv */
`default_nettype none

module jam_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  jam_pkg::cost_t   in_cost,
	output logic             out_valid,
	output jam_pkg::result_t out_data
);
	import jam_pkg::*;

	// ----------------------------------------
	// stage wires
	// ----------------------------------------
	logic      row_we;
	row_wr_t   row_wr;
	logic      load_done;
	logic      col_we;
	col_wr_t   col_wr;
	logic      reduce_done;
	logic      cover_done;
	line_cnt_t lines;
	logic      out_done;
	matrix_t   matrix;   // shared view of the store

	cost_loader u_loader (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_cost   (in_cost),
		.out_done  (out_done),
		.row_we    (row_we),
		.row_wr    (row_wr),
		.load_done (load_done)
	);

	cost_matrix u_matrix (
		.clk    (clk),
		.rst_n  (rst_n),
		.row_we (row_we),
		.row_wr (row_wr),
		.col_we (col_we),
		.col_wr (col_wr),
		.matrix (matrix)
	);

	col_reducer u_reducer (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (load_done),
		.matrix (matrix),
		.col_we (col_we),
		.col_wr (col_wr),
		.done   (reduce_done)
	);

	line_cover u_cover (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (reduce_done),
		.matrix (matrix),
		.done   (cover_done),
		.lines  (lines)
	);

	result_streamer u_streamer (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (cover_done),
		.matrix    (matrix),
		.lines     (lines),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_done  (out_done)
	);

endmodule

`default_nettype wire

/* src/line_cover.sv */
`default_nettype none

module line_cover (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  jam_pkg::matrix_t   matrix,
	output logic               done,
	output jam_pkg::line_cnt_t lines
);
	import jam_pkg::*;

	logic            busy;
	line_cnt_t       drawn;
	cnt_t [DIM-1:0]  row_cnt, col_cnt;    // uncovered zeros per line
	cnt_t [DIM-1:0]  row_init, col_init;
	cnt_t [DIM-1:0]  row_nxt, col_nxt;
	cnt_t            row_max, col_max;
	idx_t            row_sel, col_sel;
	logic            take_col;
	logic            all_clear;

	// ----------------------------------------
	// zero counts straight from the matrix
	// ----------------------------------------
	always_comb begin
		row_init = '0;
		col_init = '0;
		for (int r = 0; r < DIM; r++) begin
			for (int c = 0; c < DIM; c++) begin
				if (matrix[r][c] == '0) begin
					row_init[r] = row_init[r] + 1'b1;
					col_init[c] = col_init[c] + 1'b1;
				end
			end
		end
	end

	// ----------------------------------------
	// greedy pick, strict compare keeps the lowest index
	// ----------------------------------------
	always_comb begin
		row_max = '0;
		row_sel = '0;
		col_max = '0;
		col_sel = '0;
		for (int i = 0; i < DIM; i++) begin
			if (row_cnt[i] > row_max) begin
				row_max = row_cnt[i];
				row_sel = idx_t'(i);
			end
			if (col_cnt[i] > col_max) begin
				col_max = col_cnt[i];
				col_sel = idx_t'(i);
			end
		end
		take_col = (col_max > row_max);  // rows win a tie
	end

	// crossing lines lose one zero, drawn lines are already at zero
	always_comb begin
		row_nxt = row_cnt;
		col_nxt = col_cnt;
		if (take_col) begin
			col_nxt[col_sel] = '0;
			for (int r = 0; r < DIM; r++) begin
				if (matrix[r][col_sel] == '0 && row_cnt[r] != '0)
					row_nxt[r] = row_cnt[r] - 1'b1;
			end
		end else begin
			row_nxt[row_sel] = '0;
			for (int c = 0; c < DIM; c++) begin
				if (matrix[row_sel][c] == '0 && col_cnt[c] != '0)
					col_nxt[c] = col_cnt[c] - 1'b1;
			end
		end
		all_clear = (row_nxt == '0) && (col_nxt == '0);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			drawn   <= '0;
			row_cnt <= '0;
			col_cnt <= '0;
			done    <= 1'b0;
			lines   <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy    <= 1'b1;
				drawn   <= '0;
				row_cnt <= row_init;
				col_cnt <= col_init;
			end else if (busy) begin  // one line per cycle
				row_cnt <= row_nxt;
				col_cnt <= col_nxt;
				drawn   <= drawn + 1'b1;
				if (all_clear) begin
					busy  <= 1'b0;
					done  <= 1'b1;
					lines <= drawn + 1'b1;  // held until the next matrix
				end
			end
		end
	end

	// every row holds a zero after reduction, so 1..8 lines
	a_line_range: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (lines != '0 && lines <= line_cnt_t'(DIM)));

endmodule

`default_nettype wire

/* src/result_streamer.sv */
`default_nettype none

module result_streamer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  jam_pkg::matrix_t   matrix,
	input  jam_pkg::line_cnt_t lines,
	output logic               out_valid,
	output jam_pkg::result_t   out_data,
	output logic               out_done
);
	import jam_pkg::*;

	idx_t      beat;      // row on out_data now
	idx_t      next_row;
	line_cnt_t lines_q;

	assign next_row = beat + 1'b1;
	assign out_done = out_valid && (beat == idx_t'(DIM-1));  // with the last beat

	// ----------------------------------------
	// beat control
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			beat      <= '0;
		end else if (start) begin
			out_valid <= 1'b1;
			beat      <= '0;
		end else if (out_valid) begin
			if (beat == idx_t'(DIM-1))
				out_valid <= 1'b0;
			else
				beat <= next_row;
		end
	end

	// registered payload
	always_ff @(posedge clk) begin
		if (start) begin
			lines_q  <= lines;
			out_data <= '{row: matrix[0], lines: lines};
		end else if (out_valid && beat != idx_t'(DIM-1)) begin
			out_data <= '{row: matrix[next_row], lines: lines_q};
		end
	end

endmodule

`default_nettype wire

/* verification/jam_checker.sv */
`default_nettype none

module jam_checker (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  jam_pkg::cost_t     in_cost,
	input  logic               out_valid,
	input  jam_pkg::result_t   out_data,
	input  int                 exp_lines,   // from the case table, -1 when unknown
	output int                 value_errs,
	output int                 proto_errs,
	output int                 table_errs
);
	import jam_pkg::*;

	cost_t     in_mat [DIM][DIM];
	row_t      exp_rows [DIM];
	row_t      got_rows [DIM];
	line_cnt_t model_lines;
	int        k        = 0;   // costs captured of the current matrix
	int        loaded   = 0;   // matrices fully captured
	int        streamed = 0;   // results closed against a model
	int        beat     = 0;
	logic      was_valid = 1'b0;
	int        v_errs   = 0;
	int        p_errs   = 0;
	int        t_errs   = 0;

	assign value_errs = v_errs;
	assign proto_errs = p_errs;
	assign table_errs = t_errs;

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	task automatic compute_model();
		cost_t mn;
		int    rc [DIM];
		int    cc [DIM];
		int    best_r, best_c, br, bc, drawn;
		bit    any;
		for (int r = 0; r < DIM; r++) begin  // row minimum off each row
			mn = in_mat[r][0];
			for (int c = 1; c < DIM; c++)
				if (in_mat[r][c] < mn) mn = in_mat[r][c];
			for (int c = 0; c < DIM; c++)
				exp_rows[r][c] = in_mat[r][c] - mn;
		end
		for (int c = 0; c < DIM; c++) begin  // then column minimum
			mn = exp_rows[0][c];
			for (int r = 1; r < DIM; r++)
				if (exp_rows[r][c] < mn) mn = exp_rows[r][c];
			for (int r = 0; r < DIM; r++)
				exp_rows[r][c] = exp_rows[r][c] - mn;
		end
		for (int i = 0; i < DIM; i++) begin
			rc[i] = 0;
			cc[i] = 0;
		end
		for (int r = 0; r < DIM; r++)
			for (int c = 0; c < DIM; c++)
				if (exp_rows[r][c] == '0) begin
					rc[r] = rc[r] + 1;
					cc[c] = cc[c] + 1;
				end
		drawn = 0;
		any   = 1'b1;
		while (any && drawn < 2*DIM) begin
			best_r = 0;
			best_c = 0;
			br     = 0;
			bc     = 0;
			for (int i = 0; i < DIM; i++) begin
				if (rc[i] > best_r) begin
					best_r = rc[i];
					br     = i;
				end
				if (cc[i] > best_c) begin
					best_c = cc[i];
					bc     = i;
				end
			end
			if (best_c > best_r) begin  // column only when strictly better
				cc[bc] = 0;
				for (int r = 0; r < DIM; r++)
					if (exp_rows[r][bc] == '0 && rc[r] > 0) rc[r] = rc[r] - 1;
			end else begin
				rc[br] = 0;
				for (int c = 0; c < DIM; c++)
					if (exp_rows[br][c] == '0 && cc[c] > 0) cc[c] = cc[c] - 1;
			end
			drawn = drawn + 1;
			any   = 1'b0;
			for (int i = 0; i < DIM; i++)
				if (rc[i] != 0 || cc[i] != 0) any = 1'b1;
		end
		model_lines = line_cnt_t'(drawn);
	endtask

	// input capture, inputs change on the falling edge
	always @(posedge clk) begin
		if (!rst_n) begin
			k = 0;
		end else if (in_valid) begin
			in_mat[k/DIM][k%DIM] = in_cost;
			k = k + 1;
			if (k == DIM*DIM) begin
				compute_model();
				if (exp_lines >= 0 && int'(model_lines) != exp_lines) begin
					$display("reference model gives %0d lines but the case table expects %0d",
						model_lines, exp_lines);
					t_errs = t_errs + 1;
				end
				loaded = loaded + 1;
				k      = 0;
			end
		end
	end

	// ----------------------------------------
	// output side, sampled mid cycle
	// ----------------------------------------
	task automatic check_beat();
		bit has_zero;
		if (loaded == streamed) begin
			if (beat == 0) begin
				$display("out_valid went high at %0t with no fully loaded matrix", $time);
				p_errs = p_errs + 1;
			end
		end else if (beat >= DIM) begin
			$display("out_valid still high at %0t after 8 beats", $time);
			p_errs = p_errs + 1;
		end else begin
			got_rows[beat] = out_data.row;
			if (out_data.row !== exp_rows[beat]) begin
				$display("[FAIL] t=%0t out_data.row (row %0d): expected %h, got %h",
					$time, beat, exp_rows[beat], out_data.row);
				v_errs = v_errs + 1;
			end
			if (out_data.lines !== model_lines) begin
				$display("[FAIL] t=%0t out_data.lines (row %0d): expected %0d, got %0d",
					$time, beat, model_lines, out_data.lines);
				v_errs = v_errs + 1;
			end
			has_zero = 1'b0;
			for (int c = 0; c < DIM; c++)
				if (out_data.row[c] == '0) has_zero = 1'b1;
			if (!has_zero) begin
				$display("row %0d of the result has no zero after reduction", beat);
				v_errs = v_errs + 1;
			end
		end
		beat = beat + 1;
	endtask

	task automatic close_result();
		cost_t mn;
		if (beat != DIM) begin
			$display("result had %0d out_valid beats instead of 8", beat);
			p_errs = p_errs + 1;
		end else if (loaded > streamed) begin
			for (int c = 0; c < DIM; c++) begin
				mn = got_rows[0][c];
				for (int r = 1; r < DIM; r++)
					if (got_rows[r][c] < mn) mn = got_rows[r][c];
				if (mn != '0) begin
					$display("column %0d of the result has no zero after reduction", c);
					v_errs = v_errs + 1;
				end
			end
		end
		if (loaded > streamed)
			streamed = streamed + 1;
		beat = 0;
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid)
				check_beat();
			else if (was_valid)
				close_result();  // burst just ended
			was_valid = out_valid;
		end
	end

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	// release away from the rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* verification/tb_top.sv */
`default_nettype none

module tb_top;
	import jam_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 10;
	localparam int TIMEOUT    = 500;   // cycles per wait
	localparam int NUM_RAND   = 20;
	localparam int NUM_CASES  = 3 + NUM_RAND;

	typedef enum {FILL_EXPLICIT, FILL_CONST, FILL_RANDOM} fill_t;

	typedef struct {
		fill_t mode;
		int    value;      // pattern select or constant
		int    exp_lines;  // -1 when not fixed by the table
	} case_t;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	cost_t     in_cost;
	logic      out_valid;
	result_t   out_data;
	int        exp_lines;
	int        value_errs, proto_errs, table_errs;
	int        timeouts = 0;
	bit        aborted  = 1'b0;
	logic [15:0] lfsr   = 16'd76;
	case_t     cases [NUM_CASES];

	tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) clkgen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	jam_top uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_cost   (in_cost),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	jam_checker chk (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_cost    (in_cost),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.exp_lines  (exp_lines),
		.value_errs (value_errs),
		.proto_errs (proto_errs),
		.table_errs (table_errs)
	);

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic rand_cost(output cost_t v);
		v = '0;
		repeat (COST_W) begin  // one step per bit
			lfsr = lfsr_step(lfsr);
			v    = {v[COST_W-2:0], lfsr[0]};
		end
	endtask

	// sel 0 is a zero diagonal over 5s and sel 1 shifts 1..8 along each row
	function automatic matrix_t pattern_matrix(input int sel);
		matrix_t p;
		for (int r = 0; r < DIM; r++)
			for (int c = 0; c < DIM; c++)
				if (sel == 0)
					p[r][c] = (r == c) ? cost_t'(0) : cost_t'(5);
				else
					p[r][c] = cost_t'(((r + c) % DIM) + 1);
		return p;
	endfunction

	task automatic fill_matrix(input int n, output matrix_t m);
		cost_t v;
		m = '0;
		case (cases[n].mode)
			FILL_EXPLICIT: m = pattern_matrix(cases[n].value);
			FILL_CONST: begin
				for (int r = 0; r < DIM; r++)
					for (int c = 0; c < DIM; c++)
						m[r][c] = cost_t'(cases[n].value);
			end
			default: begin
				for (int r = 0; r < DIM; r++)
					for (int c = 0; c < DIM; c++) begin
						rand_cost(v);
						m[r][c] = v;
					end
			end
		endcase
	endtask

	task automatic drive_matrix(input matrix_t m);
		for (int k = 0; k < DIM*DIM; k++) begin  // row-major
			@(negedge clk);
			in_valid = 1'b1;
			in_cost  = m[k/DIM][k%DIM];
		end
		@(negedge clk);
		in_valid = 1'b0;
		in_cost  = '0;
	endtask

	task automatic wait_result(output bit ok);
		int cycles;
		int beats;
		cycles = 0;
		beats  = 0;
		while (beats < DIM && cycles < TIMEOUT) begin
			@(negedge clk);
			if (out_valid) beats = beats + 1;
			cycles = cycles + 1;
		end
		ok = (beats == DIM);
	endtask

	task automatic wait_idle(output bit ok);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles = cycles + 1;
		end while ((out_valid || !rst_n) && cycles < TIMEOUT);
		ok = !out_valid && rst_n;
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		matrix_t m;
		bit      ok;
		int      total;
		in_valid  = 1'b0;
		in_cost   = '0;
		exp_lines = -1;
		cases[0]  = '{FILL_EXPLICIT, 0, 8};  // zero diagonal
		cases[1]  = '{FILL_CONST, 9, 8};     // all zeros after reduction
		cases[2]  = '{FILL_EXPLICIT, 1, 8};  // one zero per row and column
		for (int i = 3; i < NUM_CASES; i++)
			cases[i] = '{FILL_RANDOM, 0, -1};

		wait_idle(ok);  // also covers reset release
		if (!ok) begin
			$display("reset was not released or out_valid stuck high after reset");
			timeouts = timeouts + 1;
			aborted  = 1'b1;
		end

		for (int i = 0; i < NUM_CASES && !aborted; i++) begin
			fill_matrix(i, m);
			exp_lines = cases[i].exp_lines;
			drive_matrix(m);
			wait_result(ok);
			if (!ok) begin
				$display("case %0d timed out waiting for 8 out_valid beats", i);
				timeouts = timeouts + 1;
				aborted  = 1'b1;
			end
		end

		if (!aborted) begin
			wait_idle(ok);  // let the checker close the last result
			if (!ok) begin
				$display("out_valid did not drop after the last result");
				timeouts = timeouts + 1;
			end
		end

		// checker closes the last result on the falling edge
		@(posedge clk);

		total = value_errs + proto_errs + table_errs + timeouts;
		$display("errors: value %0d, protocol %0d, table %0d, timeout %0d",
			value_errs, proto_errs, table_errs, timeouts);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire
